// File: rtl/centipede_pkg.sv
// address map constants, field widths and packed bus, select, input and status types
`default_nettype none

package centipede_pkg;

	// bus widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// 1 KB region select bits, a13..a10
	localparam int SEL_HI = 13;
	localparam int SEL_LO = 10;
	localparam int REG_W = SEL_HI - SEL_LO + 1;

	// regions kept on this board
	localparam logic [REG_W-1:0] REG_SWRD     = 4'd2;
	localparam logic [REG_W-1:0] REG_IN       = 4'd3;
	localparam logic [REG_W-1:0] REG_EA       = 4'd5;
	localparam logic [REG_W-1:0] REG_OUT0     = 4'd7;
	localparam logic [REG_W-1:0] REG_STEERCLR = 4'd9;

	// earom function on a8..a7, valid with a9 set
	localparam logic [1:0] EA_FN_READ = 2'd0;
	localparam logic [1:0] EA_FN_CTRL = 2'd1;
	localparam logic [1:0] EA_FN_ADDR = 2'd2;

	// trackball count field in the in0/in1 bytes
	localparam int TRAK_CNT_W = 4;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic              wr;
	} cpu_bus_t;

	// levels for reads, one-cycle pulses for writes
	typedef struct packed {
		logic swrd;
		logic in0;
		logic in1;
		logic ea_read;
		logic out0_wr;
		logic steerclr_wr;
		logic ea_ctrl_wr;
		logic ea_addr_wr;
	} io_sel_t;

	typedef struct packed {
		logic coin_r;
		logic coin_c;
		logic coin_l;
		logic self_test;
		logic cocktail;
		logic slam;
		logic start2;
		logic start1;
		logic fire2;
		logic fire1;
	} player_in_t;

	// both players, same order as the harness pins
	typedef struct packed {
		logic p1_h_dir;
		logic p2_h_dir;
		logic p1_h_ck;
		logic p2_h_ck;
		logic p1_v_dir;
		logic p2_v_dir;
		logic p1_v_ck;
		logic p2_v_ck;
	} trakball_t;

	typedef struct packed {
		logic                  dir_h;
		logic                  dir_v;
		logic [TRAK_CNT_W-1:0] count_h;
		logic [TRAK_CNT_W-1:0] count_v;
	} trak_status_t;

	// bit 7 down to bit 0 of the addressable latch
	typedef struct packed {
		logic       flip;
		logic [4:1] leds;
		logic       coin_r;
		logic       coin_c;
		logic       coin_l;
	} out_latch_t;

endpackage

`default_nettype wire

// File: rtl/io_addr_decode.sv
// i/o address decoder producing read selects and write pulses
`timescale 1ns/1ps
`default_nettype none

module io_addr_decode (
	input  wire centipede_pkg::cpu_bus_t bus_i,
	output centipede_pkg::io_sel_t       sel_o
);

	logic [centipede_pkg::REG_W-1:0] region;
	logic                            ea_bank;
	logic [1:0]                      ea_fn;

	// a15/a14 not decoded, map mirrors
	assign region = bus_i.addr[centipede_pkg::SEL_HI:centipede_pkg::SEL_LO];

	// earom lives in the upper half of region 5
	assign ea_bank = (region == centipede_pkg::REG_EA) && bus_i.addr[9];
	assign ea_fn = bus_i.addr[8:7];

	always_comb
	begin
		// switch bank, a0 picks sw1/sw2 later
		sel_o.swrd = (region == centipede_pkg::REG_SWRD);
		// in0 and in1 share a region, split on a1
		sel_o.in0 = (region == centipede_pkg::REG_IN) && !bus_i.addr[1];
		sel_o.in1 = (region == centipede_pkg::REG_IN) && bus_i.addr[1];
		sel_o.ea_read = ea_bank && (ea_fn == centipede_pkg::EA_FN_READ);

		// write pulses, one per strobe
		sel_o.out0_wr = bus_i.wr && (region == centipede_pkg::REG_OUT0);
		sel_o.steerclr_wr = bus_i.wr && (region == centipede_pkg::REG_STEERCLR);
		sel_o.ea_ctrl_wr = bus_i.wr && ea_bank && (ea_fn == centipede_pkg::EA_FN_CTRL);
		sel_o.ea_addr_wr = bus_i.wr && ea_bank && (ea_fn == centipede_pkg::EA_FN_ADDR);
	end

endmodule

`default_nettype wire

// File: rtl/io_read_mux.sv
// read data multiplexer for switches, player inputs, joysticks, trackball and earom
`timescale 1ns/1ps
`default_nettype none

module io_read_mux (
	input  wire centipede_pkg::cpu_bus_t                bus_i,
	input  wire centipede_pkg::io_sel_t                 sel_i,
	input  wire centipede_pkg::player_in_t              player_i,
	input  wire logic [centipede_pkg::DATA_W-1:0]       joystick_i,
	input  wire logic [centipede_pkg::DATA_W-1:0]       sw1_i,
	input  wire logic [centipede_pkg::DATA_W-1:0]       sw2_i,
	input  wire logic                                   vblank_i,
	input  wire centipede_pkg::trak_status_t            trak_i,
	input  wire logic [centipede_pkg::DATA_W-1:0]       ea_rdata_i,
	output logic [centipede_pkg::DATA_W-1:0]            rdata_o
);

	logic [centipede_pkg::DATA_W-1:0] in0_byte;
	logic [centipede_pkg::DATA_W-1:0] in1_byte;
	logic [centipede_pkg::DATA_W-1:0] sw_byte;

	// a0 set: buttons, a0 clear: horizontal trackball and cabinet bits
	assign in0_byte = bus_i.addr[0] ?
		{player_i.coin_r, player_i.coin_c, player_i.coin_l, player_i.slam,
			player_i.fire2, player_i.fire1, player_i.start2, player_i.start1} :
		{trak_i.dir_h, vblank_i, player_i.self_test, player_i.cocktail, trak_i.count_h};

	// a0 set: both joysticks, a0 clear: vertical trackball
	assign in1_byte = bus_i.addr[0] ? joystick_i : {trak_i.dir_v, 3'b000, trak_i.count_v};

	// option switches
	assign sw_byte = bus_i.addr[0] ? sw2_i : sw1_i;

	always_comb
	begin
		// selects are exclusive, unmapped reads float to zero
		rdata_o = '0;
		if (sel_i.swrd)
			rdata_o = sw_byte;
		else if (sel_i.in0)
			rdata_o = in0_byte;
		else if (sel_i.in1)
			rdata_o = in1_byte;
		else if (sel_i.ea_read)
			rdata_o = ea_rdata_i;
	end

endmodule

`default_nettype wire

// File: rtl/trakball_port.sv
// trackball player select, input synchronizers, direction latches and axis counters
`timescale 1ns/1ps
`default_nettype none

module trakball_port #(
	parameter int TB_CTR_W = 4
) (
	input  wire logic                         s_6mhz,
	input  wire logic                         reset,
	input  wire centipede_pkg::trakball_t     trakball_i,
	input  wire logic                         flip_i,
	input  wire logic                         steerclr_i,
	output centipede_pkg::trak_status_t       status_o
);

	localparam int CNT_W = centipede_pkg::TRAK_CNT_W;

	// index 0 horizontal, index 1 vertical
	logic [1:0]          ck_sel;
	logic [1:0]          dir_sel;
	logic [1:0]          ck_meta;
	logic [1:0]          ck_sync;
	logic [1:0]          ck_last;
	logic [1:0]          dir_meta;
	logic [1:0]          dir_sync;
	logic [1:0]          step;
	logic [1:0]          step_dir;
	logic [1:0]          dir_q;
	logic [TB_CTR_W-1:0] ctr [0:1];

	// cocktail flip hands the ball to player 1
	assign ck_sel = flip_i ? {trakball_i.p1_v_ck, trakball_i.p1_h_ck} :
		{trakball_i.p2_v_ck, trakball_i.p2_h_ck};
	assign dir_sel = flip_i ? {trakball_i.p1_v_dir, trakball_i.p1_h_dir} :
		{trakball_i.p2_v_dir, trakball_i.p2_h_dir};

	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
		begin
			ck_meta <= '0;
			ck_sync <= '0;
			ck_last <= '0;
			dir_meta <= '0;
			dir_sync <= '0;
			step <= '0;
			step_dir <= '0;
			dir_q <= '0;
			ctr[0] <= '0;
			ctr[1] <= '0;
		end
		else
		begin
			// two flop synchronizer, then edge history
			ck_meta <= ck_sel;
			ck_sync <= ck_meta;
			ck_last <= ck_sync;
			dir_meta <= dir_sel;
			dir_sync <= dir_meta;
			// registered rising edge, with the direction seen at that edge
			step <= ck_sync & ~ck_last;
			step_dir <= dir_sync;
			for (int i = 0; i < 2; i++)
			begin
				// steering clear wins over a pending step
				if (steerclr_i)
					ctr[i] <= '0;
				else if (step[i])
					ctr[i] <= dir_q[i] ? ctr[i] + 1'b1 : ctr[i] - 1'b1;
				// count uses the old direction, like the quadrature flop on the board
				if (step[i])
					dir_q[i] <= step_dir[i];
			end
		end
	end

	always_comb
	begin
		status_o.dir_h = dir_q[0];
		status_o.dir_v = dir_q[1];
		status_o.count_h = CNT_W'(ctr[0]);
		status_o.count_v = CNT_W'(ctr[1]);
	end

endmodule

`default_nettype wire

// File: rtl/coin_led_latch.sv
// addressable output latch for flip, start leds and coin counters
`timescale 1ns/1ps
`default_nettype none

module coin_led_latch (
	input  wire logic                s_6mhz,
	input  wire logic                reset,
	input  wire logic                out0_wr_i,
	input  wire logic [2:0]          addr_i,
	input  wire logic                bit_i,
	output centipede_pkg::out_latch_t latch_o
);

	logic [7:0] cc_latch;

	// one bit per write, a2..a0 picks it, d7 is the value
	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
			cc_latch <= '0;
		else if (out0_wr_i)
			cc_latch[addr_i] <= bit_i;
	end

	// bit 7 flip, 6..3 leds, 2..0 coin counters
	assign latch_o = centipede_pkg::out_latch_t'(cc_latch);

endmodule

`default_nettype wire

// File: rtl/earom_store.sv
// high score earom with address, data and control latches, store and host port
`timescale 1ns/1ps
`default_nettype none

module earom_store #(
	parameter int EAROM_AW = 6
) (
	input  wire logic                                   s_6mhz,
	input  wire logic                                   reset,
	input  wire logic                                   ea_addr_wr_i,
	input  wire logic                                   ea_ctrl_wr_i,
	input  wire centipede_pkg::cpu_bus_t                bus_i,
	output logic [centipede_pkg::DATA_W-1:0]            ea_rdata_o,
	input  wire logic [EAROM_AW-1:0]                    hs_addr_i,
	input  wire logic [centipede_pkg::DATA_W-1:0]       hs_wdata_i,
	input  wire logic                                   hs_we_i,
	output logic [centipede_pkg::DATA_W-1:0]            hs_rdata_o
);

	localparam int DEPTH = 2 ** EAROM_AW;

	logic [EAROM_AW-1:0]              ea_addr;
	logic [centipede_pkg::DATA_W-1:0] ea_data;
	logic                             ea_cs;
	logic                             ea_erase;
	logic                             ea_write;
	logic [centipede_pkg::DATA_W-1:0] mem [0:DEPTH-1];

	// latches loaded by the cpu
	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
		begin
			ea_addr <= '0;
			ea_data <= '0;
			ea_cs <= 1'b0;
			ea_erase <= 1'b0;
			ea_write <= 1'b0;
		end
		else
		begin
			// address comes from the low address bits, data rides along
			if (ea_addr_wr_i)
			begin
				ea_addr <= bus_i.addr[EAROM_AW-1:0];
				ea_data <= bus_i.wdata;
			end
			// d3 chip select, d2 erase, d1 write
			if (ea_ctrl_wr_i)
			begin
				ea_cs <= bus_i.wdata[3];
				ea_erase <= bus_i.wdata[2];
				ea_write <= bus_i.wdata[1];
			end
		end
	end

	// store, cpu side and host side in one block
	always_ff @(posedge s_6mhz)
	begin
		if (ea_cs)
		begin
			if (ea_write)
				mem[ea_addr] <= ea_erase ? '0 : ea_data;
			else
				ea_rdata_o <= mem[ea_addr];
		end
		// host write lands last, so it wins a same-address clash
		if (hs_we_i)
			mem[hs_addr_i] <= hs_wdata_i;
		hs_rdata_o <= mem[hs_addr_i];
	end

endmodule

`default_nettype wire

// File: rtl/centipede_io_top.sv
// top level of the centipede i/o board, decoder, read mux, trackball, latch and earom
`timescale 1ns/1ps
`default_nettype none

module centipede_io_top #(
	parameter int TB_CTR_W = 4,
	parameter int EAROM_AW = 6
) (
	input  wire logic                             s_6mhz,
	input  wire logic                             reset,
	input  wire centipede_pkg::cpu_bus_t          bus_i,
	input  wire centipede_pkg::player_in_t        player_i,
	input  wire centipede_pkg::trakball_t         trakball_i,
	input  wire logic [centipede_pkg::DATA_W-1:0] joystick_i,
	input  wire logic [centipede_pkg::DATA_W-1:0] sw1_i,
	input  wire logic [centipede_pkg::DATA_W-1:0] sw2_i,
	input  wire logic                             vblank_i,
	input  wire logic [EAROM_AW-1:0]              hs_addr_i,
	input  wire logic [centipede_pkg::DATA_W-1:0] hs_wdata_i,
	input  wire logic                             hs_we_i,
	output logic [centipede_pkg::DATA_W-1:0]      rdata_o,
	output logic                                  flip_o,
	output logic [4:1]                            led_o,
	output logic [2:0]                            coin_o,
	output logic [centipede_pkg::DATA_W-1:0]      hs_rdata_o
);

	centipede_pkg::io_sel_t           sel;
	centipede_pkg::trak_status_t      trak_status;
	centipede_pkg::out_latch_t        out_latch;
	logic [centipede_pkg::DATA_W-1:0] ea_rdata;

	io_addr_decode u_decode (
		.bus_i (bus_i),
		.sel_o (sel)
	);

	io_read_mux u_read_mux (
		.bus_i      (bus_i),
		.sel_i      (sel),
		.player_i   (player_i),
		.joystick_i (joystick_i),
		.sw1_i      (sw1_i),
		.sw2_i      (sw2_i),
		.vblank_i   (vblank_i),
		.trak_i     (trak_status),
		.ea_rdata_i (ea_rdata),
		.rdata_o    (rdata_o)
	);

	// flip from the output latch picks which player's ball counts
	trakball_port #(.TB_CTR_W(TB_CTR_W)) u_trakball (
		.s_6mhz     (s_6mhz),
		.reset      (reset),
		.trakball_i (trakball_i),
		.flip_i     (out_latch.flip),
		.steerclr_i (sel.steerclr_wr),
		.status_o   (trak_status)
	);

	coin_led_latch u_latch (
		.s_6mhz    (s_6mhz),
		.reset     (reset),
		.out0_wr_i (sel.out0_wr),
		.addr_i    (bus_i.addr[2:0]),
		.bit_i     (bus_i.wdata[7]),
		.latch_o   (out_latch)
	);

	earom_store #(.EAROM_AW(EAROM_AW)) u_earom (
		.s_6mhz       (s_6mhz),
		.reset        (reset),
		.ea_addr_wr_i (sel.ea_addr_wr),
		.ea_ctrl_wr_i (sel.ea_ctrl_wr),
		.bus_i        (bus_i),
		.ea_rdata_o   (ea_rdata),
		.hs_addr_i    (hs_addr_i),
		.hs_wdata_i   (hs_wdata_i),
		.hs_we_i      (hs_we_i),
		.hs_rdata_o   (hs_rdata_o)
	);

	// latch fields out to the pins
	assign flip_o = out_latch.flip;
	assign led_o = out_latch.leds;
	assign coin_o = {out_latch.coin_r, out_latch.coin_c, out_latch.coin_l};

endmodule

`default_nettype wire

// File: tests/tb_io_tasks.svh
// bus and host port tasks, expected byte helpers and value check for the i/o board testbench
`ifndef TB_IO_TASKS_SVH
`define TB_IO_TASKS_SVH

// compare one byte, count and report a mismatch
task automatic check_value(input string name, input logic [7:0] expected,
	input logic [7:0] actual);
	assert (actual === expected)
	else
	begin
		errors++;
		$display("ERROR %s expected 0x%h actual 0x%h", name, expected, actual);
	end
endtask

// one-cycle write strobe, the board samples it on the next edge
task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
	@(posedge s_6mhz);
	bus.addr <= addr;
	bus.wdata <= data;
	bus.wr <= 1'b1;
	@(posedge s_6mhz);
	bus.wr <= 1'b0;
endtask

// read path is combinational, sample mid cycle
task automatic read_expect(input logic [15:0] addr, input logic [7:0] expected);
	@(posedge s_6mhz);
	bus.addr <= addr;
	bus.wr <= 1'b0;
	@(negedge s_6mhz);
	check_value($sformatf("rdata_o[%h]", addr), expected, rdata_o);
endtask

task automatic host_write(input logic [EA_AW-1:0] addr, input logic [7:0] data);
	@(posedge s_6mhz);
	hs_addr <= addr;
	hs_wdata <= data;
	hs_we <= 1'b1;
	@(posedge s_6mhz);
	hs_we <= 1'b0;
endtask

// host read data lags the address by one cycle
task automatic host_expect(input logic [EA_AW-1:0] addr, input logic [7:0] expected);
	@(posedge s_6mhz);
	hs_addr <= addr;
	@(posedge s_6mhz);
	@(negedge s_6mhz);
	check_value($sformatf("hs_rdata_o[%h]", addr), expected, hs_rdata_o);
endtask

// in0 with a0 set
function automatic logic [7:0] buttons_byte(input centipede_pkg::player_in_t p);
	return {p.coin_r, p.coin_c, p.coin_l, p.slam, p.fire2, p.fire1, p.start2, p.start1};
endfunction

// in0 with a0 clear, trackball part from the model
function automatic logic [7:0] in0_trak_byte(input centipede_pkg::player_in_t p,
	input logic vb);
	return {dirq_h, vb, p.self_test, p.cocktail, cnt_h[3:0]};
endfunction

// in1 with a0 clear
function automatic logic [7:0] in1_trak_byte();
	return {dirq_v, 3'b000, cnt_v[3:0]};
endfunction

`endif

// File: tests/tb_centipede_io.sv
// centipede i/o board testbench with clock, reset, stimulus, trackball model, watchdog and report
`timescale 1ns/1ps
`default_nettype none

module tb_centipede_io;

	localparam int CTR_W = 4;
	localparam int EA_AW = 6;
	// rough cycle budget per test
	localparam int LEN_RESET = 20;
	localparam int LEN_INPUTS = 400;
	localparam int LEN_LATCH = 100;
	localparam int LEN_TRAK = 700;
	localparam int LEN_EAROM = 280;
	localparam int WATCHDOG_CYCLES =
		2 * (LEN_RESET + LEN_INPUTS + LEN_LATCH + LEN_TRAK + LEN_EAROM);

	logic                      s_6mhz;
	logic                      reset;
	centipede_pkg::cpu_bus_t   bus;
	centipede_pkg::player_in_t player;
	centipede_pkg::trakball_t  trak;
	logic [7:0]                joystick;
	logic [7:0]                sw1;
	logic [7:0]                sw2;
	logic                      vblank;
	logic [EA_AW-1:0]          hs_addr;
	logic [7:0]                hs_wdata;
	logic                      hs_we;
	logic [7:0]                rdata_o;
	logic                      flip_o;
	logic [4:1]                led_o;
	logic [2:0]                coin_o;
	logic [7:0]                hs_rdata_o;

	int errors;
	int seed;
	// trackball model with stored direction and count per axis
	logic [CTR_W-1:0] cnt_h;
	logic [CTR_W-1:0] cnt_v;
	logic             dirq_h;
	logic             dirq_v;
	// output latch and earom contents as the board should hold them
	logic [7:0]       latch_model;
	logic [7:0]       ee_model [0:(1<<EA_AW)-1];

	`include "tb_io_tasks.svh"

	centipede_io_top #(
		.TB_CTR_W (CTR_W),
		.EAROM_AW (EA_AW)
	) uut (
		.s_6mhz     (s_6mhz),
		.reset      (reset),
		.bus_i      (bus),
		.player_i   (player),
		.trakball_i (trak),
		.joystick_i (joystick),
		.sw1_i      (sw1),
		.sw2_i      (sw2),
		.vblank_i   (vblank),
		.hs_addr_i  (hs_addr),
		.hs_wdata_i (hs_wdata),
		.hs_we_i    (hs_we),
		.rdata_o    (rdata_o),
		.flip_o     (flip_o),
		.led_o      (led_o),
		.coin_o     (coin_o),
		.hs_rdata_o (hs_rdata_o)
	);

	initial
	begin
		s_6mhz = 1'b0;
		forever #50 s_6mhz = ~s_6mhz;
	end

	// outputs stay cleared while reset is held
	always @(negedge s_6mhz)
	begin
		if (reset)
		begin
			check_value("flip_o", 8'h00, {7'b0, flip_o});
			check_value("led_o", 8'h00, {4'b0, led_o});
			check_value("coin_o", 8'h00, {5'b0, coin_o});
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge s_6mhz);
		$display("run timed out after %0d cycles without finishing", WATCHDOG_CYCLES);
		$display("TB FAILED");
		$finish;
	end

	// n pulses on both axes of one player
	// model steps only when flip selects that player
	task automatic trak_pulses(input int n, input logic p1);
		for (int i = 0; i < n; i++)
		begin
			@(posedge s_6mhz);
			if (p1)
			begin
				trak.p1_h_ck <= 1'b1;
				trak.p1_v_ck <= 1'b1;
			end
			else
			begin
				trak.p2_h_ck <= 1'b1;
				trak.p2_v_ck <= 1'b1;
			end
			if (p1 == latch_model[7])
			begin
				// count with the old direction and store the new one
				cnt_h = dirq_h ? cnt_h + 1'b1 : cnt_h - 1'b1;
				cnt_v = dirq_v ? cnt_v + 1'b1 : cnt_v - 1'b1;
				dirq_h = p1 ? trak.p1_h_dir : trak.p2_h_dir;
				dirq_v = p1 ? trak.p1_v_dir : trak.p2_v_dir;
			end
			repeat (3) @(posedge s_6mhz);
			trak.p1_h_ck <= 1'b0;
			trak.p1_v_ck <= 1'b0;
			trak.p2_h_ck <= 1'b0;
			trak.p2_v_ck <= 1'b0;
			repeat (3) @(posedge s_6mhz);
		end
		// counter settles 3 to 4 cycles after the last edge
		repeat (2) @(posedge s_6mhz);
	endtask

	task automatic trak_expect();
		read_expect(16'h0C00, in0_trak_byte(player, vblank));
		read_expect(16'h0C02, in1_trak_byte());
	endtask

	initial
	begin : main_seq
		int                        r;
		int                        k;
		logic [1:0]                mir;
		logic [15:0]               a;
		logic [7:0]                in_sw1;
		logic [7:0]                in_sw2;
		logic [7:0]                in_joy;
		centipede_pkg::player_in_t in_pl;
		logic                      in_vb;
		logic [EA_AW-1:0]          ea_list [0:3];
		logic [EA_AW-1:0]          ea;

		seed = 10;
		errors = 0;
		reset = 1'b1;
		bus = '0;
		// inputs idle high like open switches and released buttons
		player = '1;
		trak = '0;
		joystick = 8'hFF;
		sw1 = 8'hFF;
		sw2 = 8'hFF;
		vblank = 1'b1;
		hs_addr = '0;
		hs_wdata = 8'h00;
		hs_we = 1'b0;
		cnt_h = '0;
		cnt_v = '0;
		dirq_h = 1'b0;
		dirq_v = 1'b0;
		latch_model = 8'h00;
		repeat (5) @(posedge s_6mhz);
		reset <= 1'b0;

		// cleared latch and zero reads from unmapped space
		@(negedge s_6mhz);
		check_value("flip_o", 8'h00, {7'b0, flip_o});
		check_value("led_o", 8'h00, {4'b0, led_o});
		check_value("coin_o", 8'h00, {5'b0, coin_o});
		read_expect(16'h0000, 8'h00);
		read_expect(16'h1000, 8'h00);
		read_expect(16'h1400, 8'h00);
		read_expect(16'h1780, 8'h00);
		read_expect(16'h2000, 8'h00);
		read_expect(16'h3C00, 8'h00);

		// random switches, buttons and joysticks through mirrored addresses
		for (k = 0; k < 20; k++)
		begin
			r = $random(seed);
			in_sw1 = r[7:0];
			in_sw2 = r[15:8];
			in_joy = r[23:16];
			r = $random(seed);
			in_pl = centipede_pkg::player_in_t'(r[9:0]);
			in_vb = r[10];
			mir = r[15:14];
			@(posedge s_6mhz);
			sw1 <= in_sw1;
			sw2 <= in_sw2;
			joystick <= in_joy;
			player <= in_pl;
			vblank <= in_vb;
			read_expect({mir, 14'h0800}, in_sw1);
			read_expect({mir, 14'h0801}, in_sw2);
			read_expect({mir, 14'h0C01}, buttons_byte(in_pl));
			read_expect({mir, 14'h0C00}, in0_trak_byte(in_pl, in_vb));
			read_expect({mir, 14'h0C03}, in_joy);
			read_expect({mir, 14'h0C02}, in1_trak_byte());
		end

		// d7 goes into the latch bit picked by a2..a0
		for (k = 0; k < 8; k++)
		begin
			r = $random(seed);
			a = {r[15:14], 14'h1C00};
			a[2:0] = k[2:0];
			latch_model[k] = r[7];
			bus_write(a, r[7:0]);
			@(negedge s_6mhz);
			check_value("flip_o", {7'b0, latch_model[7]}, {7'b0, flip_o});
			check_value("led_o", {4'b0, latch_model[6:3]}, {4'b0, led_o});
			check_value("coin_o", {5'b0, latch_model[2:0]}, {5'b0, coin_o});
		end

		// flip clear hands the trackball to player 2
		latch_model[7] = 1'b0;
		bus_write(16'h1C07, 8'h00);
		@(posedge s_6mhz);
		trak.p2_h_dir <= 1'b1;
		trak.p2_v_dir <= 1'b0;
		trak.p1_h_dir <= 1'b0;
		trak.p1_v_dir <= 1'b1;
		repeat (3) @(posedge s_6mhz);
		trak_pulses(5, 1'b0);
		trak_expect();
		// long run wraps the 4 bit counters
		trak_pulses(19, 1'b0);
		trak_expect();

		// steering clear zeroes the counts and keeps the directions
		r = $random(seed);
		bus_write({r[15:14], 14'h2400}, r[7:0]);
		cnt_h = '0;
		cnt_v = '0;
		trak_expect();

		// player 1 ignored until flip is set
		trak_pulses(3, 1'b1);
		trak_expect();
		latch_model[7] = 1'b1;
		bus_write(16'h1C07, 8'h80);
		trak_pulses(7, 1'b1);
		trak_expect();
		trak_pulses(4, 1'b0);
		trak_expect();

		// program earom bytes through the address and control latches
		for (k = 0; k < 4; k++)
		begin
			r = $random(seed);
			ea = r[EA_AW-1:0];
			ea_list[k] = ea;
			ee_model[ea] = r[15:8];
			bus_write(16'h1700 | {10'h000, ea}, r[15:8]);
			// chip select with write and then deselect
			bus_write(16'h1680, 8'h0A);
			bus_write(16'h1680, 8'h00);
		end
		// read back through the bus and the host port
		bus_write(16'h1680, 8'h08);
		for (k = 0; k < 4; k++)
		begin
			ea = ea_list[k];
			bus_write(16'h1700 | {10'h000, ea}, 8'h00);
			read_expect(16'h1600, ee_model[ea]);
			host_expect(ea, ee_model[ea]);
		end

		// erase clears one byte
		ea = ea_list[1];
		r = $random(seed);
		bus_write(16'h1700 | {10'h000, ea}, r[7:0]);
		bus_write(16'h1680, 8'h0E);
		bus_write(16'h1680, 8'h08);
		ee_model[ea] = 8'h00;
		read_expect(16'h1600, 8'h00);
		host_expect(ea, 8'h00);

		// host write seen from the cpu side
		ea = ea_list[2];
		r = $random(seed);
		host_write(ea, r[7:0]);
		ee_model[ea] = r[7:0];
		bus_write(16'h1700 | {10'h000, ea}, 8'h00);
		read_expect(16'h1600, ee_model[ea]);

		$display("run complete, %0d errors", errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+tests
rtl/centipede_pkg.sv
rtl/io_addr_decode.sv
rtl/io_read_mux.sv
rtl/trakball_port.sv
rtl/coin_led_latch.sv
rtl/earom_store.sv
rtl/centipede_io_top.sv
tests/tb_centipede_io.sv
